//--- all.f
+incdir+logic
+incdir+test
logic/rx_pkg.sv
logic/rx_differentiator.sv
logic/rx_channel_mux.sv
logic/rx_discriminator.sv
logic/rx_sample_buffer.sv
logic/rx_top.sv
test/rx_tb.sv

//--- test/rx_tb_tests.svh
////////////////////
// directed tests and reference model, included inside rx_tb
// model assumes two samples per word; stamps compared as offsets from row 0
////////////////////

logic [31:0]          model_q[$];                // expected readout words
sample_t              model_prev [`RX_CHANNELS]; // newest sample per physical channel
logic [`RX_SEL_W-1:0] model_sel [`RX_CHANNELS];
sample_t              model_thr [`RX_CHANNELS];
logic                 model_armed;               // rows accepted

function automatic logic exceeds(input word_t w, input sample_t t);
  return ($signed(w[0]) > $signed(t)) || ($signed(w[1]) > $signed(t));
endfunction

task automatic configure(input logic [`RX_CHANNELS-1:0][`RX_SEL_W-1:0] sel,
                         input sample_t [`RX_CHANNELS-1:0] thr);
  @(negedge adc_clk);
  cfg_mux_sel   = sel;
  cfg_threshold = thr;
  cfg_write     = 1'b1;
  @(negedge adc_clk);
  cfg_write = 1'b0;
  for (int c = 0; c < `RX_CHANNELS; c++) begin
    model_sel[c] = sel[c];
    model_thr[c] = thr[c];
  end
endtask

// one drive cycle, model rows pushed in channel order
task automatic drive_cycle(input logic [`RX_CHANNELS-1:0] valid, input word_t w0,
                           input word_t w1);
  word_t src;
  logic  v;
  int    s;
  @(negedge adc_clk);
  adc_valid   = valid;
  adc_data[0] = w0;
  adc_data[1] = w1;
  for (int c = 0; c < `RX_CHANNELS; c++) begin
    s = model_sel[c];
    if (s < `RX_CHANNELS) begin
      v   = valid[s];
      src = adc_data[s];
    end else begin
      s      = s - `RX_CHANNELS;    // differentiated input of channel s
      v      = valid[s];
      src[0] = adc_data[s][0] - model_prev[s];
      src[1] = adc_data[s][1] - adc_data[s][0];
    end
    if (v && model_armed && model_q.size() < 2*`RX_BUF_ROWS && exceeds(src, model_thr[c])) begin
      model_q.push_back({1'(c), 31'(cycles)}); // stamp carries the drive cycle
      model_q.push_back(src);
    end
  end
  for (int p = 0; p < `RX_CHANNELS; p++) begin
    if (valid[p]) model_prev[p] = adc_data[p][1];
  end
endtask

task automatic idle(input int n);
  repeat (n) drive_cycle('0, '0, '0);
endtask

task automatic start_capture();
  @(negedge adc_clk);
  start = 1'b1;
  @(negedge adc_clk);
  start       = 1'b0;
  model_q     = {};
  model_armed = 1'b1;
endtask

task automatic wait_done(input string name);
  int n;
  n = 0;
  while (!capture_done && n < 50) begin
    @(negedge adc_clk);
    n++;
  end
  if (!capture_done) begin
    errors++;
    $display("%s: capture_done_o did not rise", name);
  end
endtask

task automatic stop_capture(input string name);
  idle(4);              // drain the pipeline first
  @(negedge adc_clk);
  stop = 1'b1;
  @(negedge adc_clk);
  stop        = 1'b0;
  model_armed = 1'b0;
  wait_done(name);
endtask

// readout burst into a queue, then compare with the model
task automatic read_and_compare(input string name);
  logic [31:0]           got_q[$];
  logic [`RX_TIME_W-1:0] exp_t;
  logic [`RX_TIME_W-1:0] got_t;
  int                    idle_n;
  @(negedge adc_clk);
  readout_start = 1'b1;
  @(negedge adc_clk);
  readout_start = 1'b0;
  idle_n = 0;
  while (idle_n < 6) begin // burst over after a quiet stretch
    @(negedge adc_clk);
    if (dout_valid) begin
      got_q.push_back(dout);
      check_value("dout_last_o", dout_last, got_q.size() == model_q.size());
      idle_n = 0;
    end else begin
      idle_n++;
    end
  end
  if (model_q.size() != 0 && got_q.size() == 0) begin
    errors++;
    $display("%s: no readout words came out of the buffer", name);
  end
  check_value("readout word count", got_q.size(), model_q.size());
  for (int i = 0; i < got_q.size() && i < model_q.size(); i++) begin
    if (i % 2 == 0) begin
      exp_t = model_q[i][`RX_TIME_W-1:0] - model_q[0][`RX_TIME_W-1:0];
      got_t = got_q[i][`RX_TIME_W-1:0] - got_q[0][`RX_TIME_W-1:0];
      check_value("dout_o stamp", {got_q[i][31], got_t}, {model_q[i][31], exp_t});
    end else begin
      check_value("dout_o samples", got_q[i], model_q[i]);
    end
  end
endtask

////////////////////
// tests
////////////////////
task automatic test_reset_state();
  int e;
  e = errors;
  check_value("capture_done_o", capture_done, 0);
  check_value("dout_valid_o", dout_valid, 0);
  check_value("dout_last_o", dout_last, 0);
  check_value("write_depth_o", write_depth, 0);
  read_and_compare("reset state"); // empty model, no burst allowed
  end_test("reset state", e);
endtask

task automatic test_raw_capture();
  int                       e;
  word_t                    w0;
  word_t                    w1;
  logic [`RX_CHANNELS-1:0]  v;
  e = errors;
  configure({2'd1, 2'd0}, {-16'sd500, 16'sd1000});
  start_capture();
  for (int i = 0; i < 14; i++) begin
    v  = `RX_CHANNELS'(random_word()); // random gaps in both streams
    w0 = random_word();
    w1 = random_word();
    drive_cycle(v, w0, w1);
  end
  stop_capture("raw capture");
  read_and_compare("raw capture");
  end_test("raw capture", e);
endtask

task automatic test_diff_path();
  int      e;
  word_t   w0;
  sample_t base;
  e = errors;
  configure({2'd1, 2'd2}, {16'sh7fff, 16'sd50}); // logical 0 from diff 0
  start_capture();
  base = 16'sd100;
  for (int i = 0; i < 12; i++) begin
    if (i == 6) base = base + 16'sd400; // step
    w0[0] = base;
    w0[1] = base + 16'sd10;             // ramp slope 10 per sample
    base  = base + 16'sd20;
    drive_cycle(2'b01, w0, '0);
  end
  stop_capture("diff path");
  read_and_compare("diff path");
  end_test("diff path", e);
endtask

task automatic test_fill();
  int    e;
  word_t w0;
  word_t w1;
  e = errors;
  configure({2'd1, 2'd0}, {16'sh8000, 16'sh8000}); // nearly every word kept
  start_capture();
  for (int i = 0; i < 20; i++) begin
    w0 = random_word();
    w1 = random_word();
    drive_cycle(2'b11, w0, w1);
  end
  idle(4);
  wait_done("fill");
  check_value("write_depth_o", write_depth, `RX_BUF_ROWS);
  read_and_compare("fill");
  end_test("fill", e);
endtask

task automatic test_stop_rearm();
  int e;
  e = errors;
  configure({2'd1, 2'd0}, {16'sd0, 16'sd0});
  start_capture();
  for (int i = 0; i < 3; i++) begin
    drive_cycle(2'b01, {16'sd7, 16'sd300 + 16'(i)}, '0);
  end
  stop_capture("stop");
  for (int i = 0; i < 3; i++) begin
    drive_cycle(2'b11, {16'sd9, 16'sd900}, {16'sd9, 16'sd900}); // after stop
  end
  idle(4);
  check_value("write_depth_o", write_depth, model_q.size() / 2);
  start_capture();
  check_value("capture_done_o", capture_done, 0);
  check_value("write_depth_o", write_depth, 0);
  for (int i = 0; i < 2; i++) begin
    drive_cycle(2'b10, '0, {16'sd5, 16'sd600 + 16'(i)});
  end
  stop_capture("rearm");
  read_and_compare("stop and rearm");
  end_test("stop and rearm", e);
endtask

//--- test/rx_tb.sv
////////////////////
// testbench for rx_top, directed tests come from rx_tb_tests.svh
// inputs change on the falling edge, outputs are sampled there too
////////////////////
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_tb;

  import rx_pkg::*;

  localparam int MAX_CYCLES = 4000; // five tests of ~300 cycles, with margin

  logic                                   adc_clk;
  logic                                   adc_reset;
  word_t [`RX_CHANNELS-1:0]               adc_data;
  logic [`RX_CHANNELS-1:0]                adc_valid;
  logic                                   cfg_write;
  logic [`RX_CHANNELS-1:0][`RX_SEL_W-1:0] cfg_mux_sel;
  sample_t [`RX_CHANNELS-1:0]             cfg_threshold;
  logic                                   start;
  logic                                   stop;
  logic                                   readout_start;
  logic [31:0]                            dout;
  logic                                   dout_valid;
  logic                                   dout_last;
  logic                                   capture_done;
  logic [$clog2(`RX_BUF_ROWS+1)-1:0]      write_depth;

  int          cycles;    // posedges since time zero
  int          errors;
  int          tests_run;
  logic [31:0] rng_state;

  rx_top i_dut (
    .adc_clk         (adc_clk),
    .adc_reset       (adc_reset),
    .adc_data_i      (adc_data),
    .adc_valid_i     (adc_valid),
    .cfg_write_i     (cfg_write),
    .cfg_mux_sel_i   (cfg_mux_sel),
    .cfg_threshold_i (cfg_threshold),
    .start_i         (start),
    .stop_i          (stop),
    .readout_start_i (readout_start),
    .dout_o          (dout),
    .dout_valid_o    (dout_valid),
    .dout_last_o     (dout_last),
    .capture_done_o  (capture_done),
    .write_depth_o   (write_depth)
  );

  initial adc_clk = 1'b0;
  always #10 adc_clk = ~adc_clk; // 20 ns period

  // run limit
  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // next value of the shared random stream
  function automatic word_t random_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  `include "rx_tb_tests.svh"

  initial begin
    cycles        = 0;
    errors        = 0;
    tests_run     = 0;
    rng_state     = 32'haa0cc4a6;
    adc_reset     = 1'b1;
    adc_data      = '0;
    adc_valid     = '0;
    cfg_write     = 1'b0;
    cfg_mux_sel   = '0;
    cfg_threshold = '0;
    start         = 1'b0;
    stop          = 1'b0;
    readout_start = 1'b0;
    model_armed   = 1'b0;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      model_prev[c] = '0;
      model_sel[c]  = `RX_SEL_W'(c);  // identity after reset
      model_thr[c]  = 16'sh7fff;      // nothing kept after reset
    end
    repeat (16) @(negedge adc_clk);
    adc_reset = 1'b0;
    test_reset_state();
    test_raw_capture();
    test_diff_path();
    test_fill();
    test_stop_rearm();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- logic/rx_top.sv
////////////////////
// receive chain top, single adc_clk domain
// no back-pressure, readout words must be taken as they come
////////////////////
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_top (
  input  logic                                   adc_clk,
  input  logic                                   adc_reset,
  input  rx_pkg::word_t [`RX_CHANNELS-1:0]       adc_data_i,
  input  logic [`RX_CHANNELS-1:0]                adc_valid_i,
  input  logic                                   cfg_write_i,
  input  logic [`RX_CHANNELS-1:0][`RX_SEL_W-1:0] cfg_mux_sel_i,
  input  rx_pkg::sample_t [`RX_CHANNELS-1:0]     cfg_threshold_i,
  input  logic                                   start_i,
  input  logic                                   stop_i,
  input  logic                                   readout_start_i,
  output logic [$bits(rx_pkg::buf_word_u)-1:0]   dout_o,
  output logic                                   dout_valid_o,
  output logic                                   dout_last_o,
  output logic                                   capture_done_o,
  output logic [$clog2(`RX_BUF_ROWS+1)-1:0]      write_depth_o
);

  rx_pkg::word_t [`RX_CHANNELS-1:0]  diff_data;   // differentiator outputs
  logic [`RX_CHANNELS-1:0]           diff_valid;
  rx_pkg::word_t [`RX_CHANNELS-1:0]  mux_data;    // logical channels
  logic [`RX_CHANNELS-1:0]           mux_valid;
  logic [`RX_CHANNELS-1:0]           disc_keep;
  rx_pkg::stamp_t [`RX_CHANNELS-1:0] disc_stamp;
  rx_pkg::word_t [`RX_CHANNELS-1:0]  disc_data;

  ////////////////////
  // per channel math
  ////////////////////
  for (genvar c = 0; c < `RX_CHANNELS; c++) begin : g_diff
    rx_differentiator i_diff (
      .adc_clk   (adc_clk),
      .adc_reset (adc_reset),
      .data_i    (adc_data_i[c]),
      .valid_i   (adc_valid_i[c]),
      .data_o    (diff_data[c]),
      .valid_o   (diff_valid[c])
    );
  end

  // raw and differentiated streams into logical channels
  rx_channel_mux i_mux (
    .adc_clk       (adc_clk),
    .adc_reset     (adc_reset),
    .raw_i         (adc_data_i),
    .diff_i        (diff_data),
    .raw_valid_i   (adc_valid_i),
    .diff_valid_i  (diff_valid),
    .cfg_write_i   (cfg_write_i),
    .cfg_mux_sel_i (cfg_mux_sel_i),
    .data_o        (mux_data),
    .valid_o       (mux_valid)
  );

  rx_discriminator i_disc (
    .adc_clk         (adc_clk),
    .adc_reset       (adc_reset),
    .data_i          (mux_data),
    .valid_i         (mux_valid),
    .cfg_write_i     (cfg_write_i),
    .cfg_threshold_i (cfg_threshold_i),
    .start_i         (start_i),
    .keep_o          (disc_keep),
    .stamp_o         (disc_stamp),
    .data_o          (disc_data)
  );

  rx_sample_buffer i_buf (
    .adc_clk         (adc_clk),
    .adc_reset       (adc_reset),
    .keep_i          (disc_keep),
    .stamp_i         (disc_stamp),
    .data_i          (disc_data),
    .start_i         (start_i),
    .stop_i          (stop_i),
    .readout_start_i (readout_start_i),
    .dout_o          (dout_o),
    .dout_valid_o    (dout_valid_o),
    .dout_last_o     (dout_last_o),
    .capture_done_o  (capture_done_o),
    .write_depth_o   (write_depth_o)
  );

endmodule

//--- logic/rx_sample_buffer.sv
////////////////////
// stores kept words as stamp/sample rows until full or stopped
// readout only after capture is done, two words per row
////////////////////
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_sample_buffer (
  input  logic                               adc_clk,
  input  logic                               adc_reset,
  input  logic [`RX_CHANNELS-1:0]            keep_i,
  input  rx_pkg::stamp_t [`RX_CHANNELS-1:0]  stamp_i,
  input  rx_pkg::word_t [`RX_CHANNELS-1:0]   data_i,
  input  logic                               start_i,
  input  logic                               stop_i,
  input  logic                               readout_start_i,
  output rx_pkg::buf_word_u                  dout_o,
  output logic                               dout_valid_o,
  output logic                               dout_last_o,
  output logic                               capture_done_o,
  output logic [$clog2(`RX_BUF_ROWS+1)-1:0]  write_depth_o
);

  import rx_pkg::*;

  localparam int AW = $clog2(`RX_BUF_ROWS);    // row address
  localparam int DW = $clog2(`RX_BUF_ROWS+1);  // row count incl. full

  buf_row_t mem [`RX_BUF_ROWS];

  logic                             armed_q;  // accepting rows
  logic                             done_q;   // capture finished
  logic [DW-1:0]                    wp_q;     // rows written
  logic [DW-1:0]                    wp_next;
  logic [`RX_CHANNELS-1:0]          wr_en;
  logic [`RX_CHANNELS-1:0][AW-1:0]  wr_addr;

  logic          rd_active_q;  // sequencer running
  logic [AW-1:0] rd_row_q;
  logic          rd_half_q;    // 0 stamp, 1 samples
  logic          rd_start;
  logic          rd_last;
  buf_row_t      row_q;        // registered memory read
  logic          half_q;

  ////////////////////
  // row allocation
  ////////////////////
  // channel 0 first, overflow rows dropped
  always_comb begin : alloc
    logic [DW-1:0] slot;
    slot = wp_q;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      wr_en[c]   = 1'b0;
      wr_addr[c] = slot[AW-1:0];
      if (armed_q && keep_i[c] && (slot < DW'(`RX_BUF_ROWS))) begin
        wr_en[c] = 1'b1;
        slot     = slot + 1'b1;
      end
    end
    wp_next = slot;
  end

  // memory and read stage, no reset
  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      if (wr_en[c]) begin
        mem[wr_addr[c]] <= buf_row_t'{stamp: stamp_i[c], samples: data_i[c]};
      end
    end
    row_q  <= mem[rd_row_q];
    half_q <= rd_half_q;
  end

  // capture control
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      armed_q <= 1'b0;
      done_q  <= 1'b0;
      wp_q    <= '0;
    end else if (start_i) begin
      armed_q <= 1'b1; // empty and arm
      done_q  <= 1'b0;
      wp_q    <= '0;
    end else if (armed_q) begin
      wp_q <= wp_next; // stop cycle still writes
      if (stop_i || (wp_next == DW'(`RX_BUF_ROWS))) begin
        armed_q <= 1'b0;
        done_q  <= 1'b1;
      end
    end
  end

  assign capture_done_o = done_q;
  assign write_depth_o  = wp_q;

  ////////////////////
  // readout sequencer
  ////////////////////
  assign rd_start = readout_start_i && done_q && !rd_active_q && (wp_q != '0);
  assign rd_last  = rd_half_q && ({1'b0, rd_row_q} == wp_q - 1'b1); // sample half of last row

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      rd_active_q  <= 1'b0;
      rd_row_q     <= '0;
      rd_half_q    <= 1'b0;
      dout_valid_o <= 1'b0;
      dout_last_o  <= 1'b0;
    end else begin
      dout_valid_o <= rd_active_q; // lines up with row_q
      dout_last_o  <= rd_active_q && rd_last;
      if (start_i) begin
        rd_active_q <= 1'b0; // new capture aborts readout
      end else if (rd_start) begin
        rd_active_q <= 1'b1;
        rd_row_q    <= '0;
        rd_half_q   <= 1'b0;
      end else if (rd_active_q) begin
        rd_half_q <= ~rd_half_q;
        if (rd_last) begin
          rd_active_q <= 1'b0;
        end else if (rd_half_q) begin
          rd_row_q <= rd_row_q + 1'b1; // next row after sample half
        end
      end
    end
  end

  // same word seen as stamp or as samples
  always_comb begin
    if (half_q) begin
      dout_o.samples = row_q.samples;
    end else begin
      dout_o.stamp = row_q.stamp;
    end
  end

endmodule

//--- logic/rx_discriminator.sv
////////////////////
// keeps words with any sample strictly above the channel threshold
// default threshold is the max sample, so nothing passes until configured
////////////////////
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_discriminator (
  input  logic                               adc_clk,
  input  logic                               adc_reset,
  input  rx_pkg::word_t [`RX_CHANNELS-1:0]   data_i,
  input  logic [`RX_CHANNELS-1:0]            valid_i,
  input  logic                               cfg_write_i,
  input  rx_pkg::sample_t [`RX_CHANNELS-1:0] cfg_threshold_i,
  input  logic                               start_i,
  output logic [`RX_CHANNELS-1:0]            keep_o,
  output rx_pkg::stamp_t [`RX_CHANNELS-1:0]  stamp_o,
  output rx_pkg::word_t [`RX_CHANNELS-1:0]   data_o
);

  import rx_pkg::*;

  sample_t [`RX_CHANNELS-1:0] thresh_q;
  logic [`RX_TIME_W-1:0]      time_q;   // free running after start
  logic [`RX_CHANNELS-1:0]    hit;      // some sample over threshold

  ////////////////////
  // threshold compare
  ////////////////////
  always_comb begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      hit[c] = 1'b0;
      for (int k = 0; k < `RX_PAR_SAMPLES; k++) begin
        if ($signed(data_i[c][k]) > $signed(thresh_q[c])) begin // signed compare
          hit[c] = 1'b1;
        end
      end
    end
  end

  // config and time count
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        thresh_q[c] <= {1'b0, {(`RX_SAMPLE_W-1){1'b1}}}; // most positive value
      end
      time_q <= '0;
    end else begin
      if (cfg_write_i) begin
        thresh_q <= cfg_threshold_i;
      end
      if (start_i) begin
        time_q <= '0; // zero on the cycle after start
      end else begin
        time_q <= time_q + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      keep_o <= '0;
    end else begin
      keep_o <= valid_i & hit; // one pulse per kept word
    end
  end

  ////////////////////
  // stamp and word, aligned with keep_o
  ////////////////////
  always_ff @(posedge adc_clk) begin
    data_o <= data_i;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      stamp_o[c].channel <= chan_t'(c);
      stamp_o[c].tstamp  <= time_q; // time the word entered
    end
  end

endmodule

//--- logic/rx_channel_mux.sv
////////////////////
// picks raw (0..N-1) or differentiated (N..2N-1) input per logical channel
// select takes effect on the cycle after cfg_write_i
////////////////////
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_channel_mux (
  input  logic                                     adc_clk,
  input  logic                                     adc_reset,
  input  rx_pkg::word_t [`RX_CHANNELS-1:0]         raw_i,
  input  rx_pkg::word_t [`RX_CHANNELS-1:0]         diff_i,
  input  logic [`RX_CHANNELS-1:0]                  raw_valid_i,
  input  logic [`RX_CHANNELS-1:0]                  diff_valid_i,
  input  logic                                     cfg_write_i,
  input  logic [`RX_CHANNELS-1:0][`RX_SEL_W-1:0]   cfg_mux_sel_i,
  output rx_pkg::word_t [`RX_CHANNELS-1:0]         data_o,
  output logic [`RX_CHANNELS-1:0]                  valid_o
);

  import rx_pkg::*;

  word_t [2*`RX_CHANNELS-1:0]            src_data;  // all mux inputs
  logic  [2*`RX_CHANNELS-1:0]            src_valid;
  logic  [`RX_CHANNELS-1:0][`RX_SEL_W-1:0] sel_q;   // latched selects

  // raw in the low half, differentiated in the high half
  assign src_data  = {diff_i, raw_i};
  assign src_valid = {diff_valid_i, raw_valid_i};

  ////////////////////
  // select registers
  ////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        sel_q[c] <= `RX_SEL_W'(c); // identity map
      end
    end else if (cfg_write_i) begin
      sel_q <= cfg_mux_sel_i;
    end
  end

  // routed words, no reset needed on data
  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      data_o[c] <= src_data[sel_q[c]];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_o <= '0;
    end else begin
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        valid_o[c] <= src_valid[sel_q[c]]; // valid follows its word
      end
    end
  end

endmodule

//--- logic/rx_differentiator.sv
////////////////////
// first difference per sample, wraps on overflow
// history only advances on valid words
////////////////////
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_differentiator (
  input  logic          adc_clk,
  input  logic          adc_reset,
  input  rx_pkg::word_t data_i,
  input  logic          valid_i,
  output rx_pkg::word_t data_o,
  output logic          valid_o
);

  import rx_pkg::*;

  sample_t prev_sample; // last sample of previous valid word
  word_t   diff;

  // sample k minus sample k-1 within the word
  always_comb begin
    diff[0] = data_i[0] - prev_sample; // crosses word boundary
    for (int k = 1; k < `RX_PAR_SAMPLES; k++) begin
      diff[k] = data_i[k] - data_i[k-1];
    end
  end

  // difference register, payload only
  always_ff @(posedge adc_clk) begin
    data_o <= diff;
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_o     <= 1'b0;
      prev_sample <= '0; // first word sees zero history
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        prev_sample <= data_i[`RX_PAR_SAMPLES-1]; // newest sample
      end
    end
  end

endmodule

//--- logic/rx_pkg.sv
////////////////////
// shared data types for the receive chain
// stamp_t must be as wide as word_t for the readout union
////////////////////
`include "rx_consts.svh"

package rx_pkg;

  // one signed adc sample
  typedef logic signed [`RX_SAMPLE_W-1:0] sample_t;

  // one cycle of samples, sample 0 oldest in the low bits
  typedef sample_t [`RX_PAR_SAMPLES-1:0] word_t;

  // logical channel index
  typedef logic [$clog2(`RX_CHANNELS)-1:0] chan_t;

  typedef struct packed {
    chan_t                  channel; // msb
    logic [`RX_TIME_W-1:0]  tstamp;  // cycles since start
  } stamp_t;

  // readout word, stamp half or sample half of a row
  typedef union packed {
    word_t  samples;
    stamp_t stamp;
  } buf_word_u;

  // one buffer entry
  typedef struct packed {
    stamp_t stamp;
    word_t  samples;
  } buf_row_t;

endpackage

//--- logic/rx_consts.svh
////////////////////
// sizes for the receive chain, fixed at build time
// RX_SEL_W must cover 2*RX_CHANNELS mux inputs
////////////////////
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// physical and logical channel count
`define RX_CHANNELS 2
// samples per word per cycle
`define RX_PAR_SAMPLES 2
// bits per sample
`define RX_SAMPLE_W 16
// sparse buffer rows (stamp + samples each)
`define RX_BUF_ROWS 32
// time count width, plus channel bit fills a stamp word
`define RX_TIME_W 31
// bits per logical channel select
`define RX_SEL_W 2

`endif
